/* hw/wavePkg.sv */
`default_nettype none

package wavePkg;

	// One screen row of the 160x120 playfield.
	typedef logic [6:0] row_t;

	// A wall tracer; dir 0 moves toward larger rows, 1 toward smaller rows.
	typedef struct packed {
		row_t pos;
		logic dir;
	} tracer_t;

	// Everything the controller needs to judge a tick.
	typedef struct packed {
		row_t ship;
		tracer_t upper;
		tracer_t lower;
	} world_t;

	localparam int SCORE_DIGITS = 6;

	// Six BCD digits, digit 0 is the least significant.
	typedef logic [SCORE_DIGITS-1:0][3:0] score_t;

	// Ship limits.
	localparam row_t SHIP_START = 7'd60;
	localparam row_t SHIP_MIN = 7'd7;
	localparam row_t SHIP_MAX = 7'd112;

	// Upper wall band.
	localparam row_t UPPER_START = 7'd30;
	localparam row_t UPPER_MIN = 7'd8;
	localparam row_t UPPER_MAX = 7'd50;

	// Lower wall band.
	localparam row_t LOWER_START = 7'd90;
	localparam row_t LOWER_MIN = 7'd70;
	localparam row_t LOWER_MAX = 7'd112;

	localparam logic [15:0] LFSR_SEED = 16'hACE1; // Must never be zero.

endpackage

`default_nettype wire

/* hw/gameTicker.sv */
`timescale 1ns/1ns
`default_nettype none

module gameTicker #(
	parameter int TICK_CYCLES = 833333
) (
	input logic clock,
	input logic reset_n,
	output logic tick
);

	localparam int COUNT_WIDTH = (TICK_CYCLES > 2) ? $clog2(TICK_CYCLES) : 1;
	localparam logic [COUNT_WIDTH-1:0] LAST_COUNT = COUNT_WIDTH'(TICK_CYCLES - 1);

	logic [COUNT_WIDTH-1:0] count; // Cycles since the last tick.
	logic lastCount;

	assign lastCount = (count == LAST_COUNT);

	always_ff @(posedge clock) begin
		if (!reset_n) begin
			count <= '0;
		end else if (lastCount) begin
			count <= '0; // Start the next period.
		end else begin
			count <= count + 1'b1;
		end
	end

	// Registered, so tick lands a full period after reset.
	always_ff @(posedge clock) begin
		if (!reset_n) begin
			tick <= 1'b0;
		end else begin
			tick <= lastCount;
		end
	end

endmodule

`default_nettype wire

/* hw/shipDatapath.sv */
`timescale 1ns/1ns
`default_nettype none

module shipDatapath import wavePkg::*; (
	input logic clock,
	input logic reset_n,
	input logic up,
	input logic loadDir,
	input logic shipStep,
	output row_t ship
);

	logic dirUp; // Direction latched while the controller idles.
	logic atTop;
	logic atBottom;
	row_t nextShip;

	// The player's button is sampled only between ticks.
	always_ff @(posedge clock) begin
		if (!reset_n) begin
			dirUp <= 1'b0;
		end else if (loadDir) begin
			dirUp <= up;
		end
	end

	assign atTop = (ship <= SHIP_MIN);
	assign atBottom = (ship >= SHIP_MAX);

	// One row per step, held at the edges of the field.
	always_comb begin
		nextShip = ship;
		if (dirUp) begin
			if (!atTop) begin
				nextShip = ship - 1'b1;
			end
		end else begin
			if (!atBottom) begin
				nextShip = ship + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (!reset_n) begin
			ship <= SHIP_START;
		end else if (shipStep) begin
			ship <= nextShip;
		end
	end

endmodule

`default_nettype wire

/* hw/hallwayTracers.sv */
`timescale 1ns/1ns
`default_nettype none

module hallwayTracers import wavePkg::*; (
	input logic clock,
	input logic reset_n,
	input logic tracerStep,
	output tracer_t upper,
	output tracer_t lower
);

	logic [15:0] lfsr; // Random source for the direction flips.
	logic feedback;
	tracer_t nextUpper;
	tracer_t nextLower;

	// Taps 16, 14, 13, 11 give a maximal length sequence.
	assign feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

	always_ff @(posedge clock) begin
		if (!reset_n) begin
			lfsr <= LFSR_SEED;
		end else if (tracerStep) begin
			lfsr <= {lfsr[14:0], feedback};
		end
	end

	// Random flip first, then the band limits win, then one row of motion.
	function automatic tracer_t stepTracer(
		input tracer_t cur,
		input logic flip,
		input row_t minRow,
		input row_t maxRow
	);
		tracer_t nxt;
		logic dir;

		dir = cur.dir ^ flip;
		if (cur.pos <= minRow) begin
			dir = 1'b0; // Bounce off the top of the band.
		end else if (cur.pos >= maxRow) begin
			dir = 1'b1; // Bounce off the bottom of the band.
		end
		nxt.dir = dir;
		if (dir) begin
			nxt.pos = cur.pos - 1'b1;
		end else begin
			nxt.pos = cur.pos + 1'b1;
		end
		return nxt;
	endfunction

	// Each wall draws on its own LFSR bit.
	assign nextUpper = stepTracer(upper, lfsr[0], UPPER_MIN, UPPER_MAX);
	assign nextLower = stepTracer(lower, lfsr[1], LOWER_MIN, LOWER_MAX);

	always_ff @(posedge clock) begin
		if (!reset_n) begin
			upper.pos <= UPPER_START;
			upper.dir <= 1'b0;
			lower.pos <= LOWER_START;
			lower.dir <= 1'b0;
		end else if (tracerStep) begin
			upper <= nextUpper;
			lower <= nextLower;
		end
	end

endmodule

`default_nettype wire

/* hw/scoreCounter.sv */
`timescale 1ns/1ns
`default_nettype none

module scoreCounter import wavePkg::*; (
	input logic clock,
	input logic reset_n,
	input logic frame,
	output score_t score
);

	localparam logic [3:0] DIGIT_MAX = 4'd9;

	score_t nextScore;

	// Ripple the increment through the BCD digits.
	always_comb begin
		logic carry;

		carry = 1'b1;
		nextScore = score;
		for (int i = 0; i < SCORE_DIGITS; i++) begin
			if (carry) begin
				if (score[i] >= DIGIT_MAX) begin
					nextScore[i] = 4'd0; // Carry keeps going.
				end else begin
					nextScore[i] = score[i] + 1'b1;
					carry = 1'b0;
				end
			end
		end
	end

	// 999999 rolls over to zero since the last carry is dropped.
	always_ff @(posedge clock) begin
		if (!reset_n) begin
			score <= '0;
		end else if (frame) begin
			score <= nextScore;
		end
	end

endmodule

`default_nettype wire

/* hw/gameController.sv */
`timescale 1ns/1ns
`default_nettype none

module gameController import wavePkg::*; (
	input logic clock,
	input logic reset_n,
	input logic tick,
	input world_t world,
	output logic loadDir,
	output logic shipStep,
	output logic tracerStep,
	output logic frame,
	output logic gameOver
);

	typedef enum logic [2:0] {
		IDLE,
		STEP_SHIP,
		STEP_WALLS,
		CHECK,
		OVER
	} state_t;

	state_t state;
	state_t nextState;
	logic clear; // Ship sits strictly between the walls.

	assign clear = (world.ship > world.upper.pos) && (world.ship < world.lower.pos);

	// One pass per tick; a collision parks the machine for good.
	always_comb begin
		nextState = state;
		case (state)
			IDLE: begin
				if (tick) begin
					nextState = STEP_SHIP;
				end
			end
			STEP_SHIP: nextState = STEP_WALLS;
			STEP_WALLS: nextState = CHECK;
			CHECK: begin
				if (clear) begin
					nextState = IDLE;
				end else begin
					nextState = OVER;
				end
			end
			OVER: nextState = OVER; // Only reset leaves.
			default: nextState = IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!reset_n) begin
			state <= IDLE;
		end else begin
			state <= nextState;
		end
	end

	assign loadDir = (state == IDLE); // Button is sampled while idle.
	assign shipStep = (state == STEP_SHIP);
	assign tracerStep = (state == STEP_WALLS);
	assign frame = (state == CHECK) && clear; // A survived tick.
	assign gameOver = (state == OVER);

endmodule

`default_nettype wire

/* hw/waveGame.sv */
`timescale 1ns/1ns
`default_nettype none

module waveGame import wavePkg::*; #(
	parameter int TICK_CYCLES = 833333
) (
	input logic clock,
	input logic reset_n,
	input logic up,
	output world_t world,
	output score_t score,
	output logic frame,
	output logic gameOver
);

	logic tick;
	logic loadDir;
	logic shipStep;
	logic tracerStep;
	row_t shipRow;
	tracer_t upperWall;
	tracer_t lowerWall;

	// Bundle the playfield for the controller and the outside.
	assign world = '{ship: shipRow, upper: upperWall, lower: lowerWall};

	gameTicker #(
		.TICK_CYCLES(TICK_CYCLES)
	) ticker (
		.clock(clock),
		.reset_n(reset_n),
		.tick(tick)
	);

	shipDatapath ship (
		.clock(clock),
		.reset_n(reset_n),
		.up(up),
		.loadDir(loadDir),
		.shipStep(shipStep),
		.ship(shipRow)
	);

	hallwayTracers walls (
		.clock(clock),
		.reset_n(reset_n),
		.tracerStep(tracerStep),
		.upper(upperWall),
		.lower(lowerWall)
	);

	gameController control (
		.clock(clock),
		.reset_n(reset_n),
		.tick(tick),
		.world(world),
		.loadDir(loadDir),
		.shipStep(shipStep),
		.tracerStep(tracerStep),
		.frame(frame),
		.gameOver(gameOver)
	);

	scoreCounter scorer (
		.clock(clock),
		.reset_n(reset_n),
		.frame(frame),
		.score(score)
	);

endmodule

`default_nettype wire

/* bench/waveGameModel.svh */
`ifndef WAVE_GAME_MODEL_SVH
`define WAVE_GAME_MODEL_SVH

world_t modelWorld; // Expected playfield after the last tick.
logic [15:0] modelLfsr; // Expected wall-direction LFSR.
int modelFrames; // Ticks survived so far.

task automatic resetModel();
	modelWorld.ship = SHIP_START;
	modelWorld.upper.pos = UPPER_START;
	modelWorld.upper.dir = 1'b0;
	modelWorld.lower.pos = LOWER_START;
	modelWorld.lower.dir = 1'b0;
	modelLfsr = LFSR_SEED;
	modelFrames = 0;
endtask

// Random flip, then the band limits, then one row of motion.
function automatic tracer_t wallStep(input tracer_t wall, input logic flip,
		input row_t lowest, input row_t highest);
	tracer_t moved;

	moved.dir = flip ? ~wall.dir : wall.dir;
	if (wall.pos == lowest) begin
		moved.dir = 1'b0;
	end else if (wall.pos == highest) begin
		moved.dir = 1'b1;
	end
	moved.pos = moved.dir ? wall.pos - 7'd1 : wall.pos + 7'd1;
	return moved;
endfunction

// One game tick; survived is low when the ship touches a wall.
task automatic stepModel(input logic upHeld, output logic survived);
	logic [15:0] oldLfsr;

	oldLfsr = modelLfsr;
	if (upHeld && modelWorld.ship > SHIP_MIN) begin
		modelWorld.ship = modelWorld.ship - 7'd1;
	end else if (!upHeld && modelWorld.ship < SHIP_MAX) begin
		modelWorld.ship = modelWorld.ship + 7'd1;
	end
	modelWorld.upper = wallStep(modelWorld.upper, oldLfsr[0], UPPER_MIN, UPPER_MAX);
	modelWorld.lower = wallStep(modelWorld.lower, oldLfsr[1], LOWER_MIN, LOWER_MAX);
	modelLfsr = {oldLfsr[14:0], oldLfsr[15] ^ oldLfsr[13] ^ oldLfsr[12] ^ oldLfsr[10]};
	survived = (modelWorld.ship > modelWorld.upper.pos) &&
		(modelWorld.ship < modelWorld.lower.pos);
	if (survived) begin
		modelFrames++;
	end
endtask

// Decimal digits of the survived count.
function automatic score_t expectedScore(input int count);
	score_t digits;
	int rest;

	rest = count % 1000000;
	for (int i = 0; i < SCORE_DIGITS; i++) begin
		digits[i] = 4'(rest % 10);
		rest = rest / 10;
	end
	return digits;
endfunction

`endif

/* bench/waveGameTb.sv */
`timescale 1ns/1ns
`default_nettype none

module waveGameTb import wavePkg::*; ();

	localparam int TICK_CYCLES = 16;
	localparam int TIMEOUT_CYCLES = 40;
	localparam int MAX_FRAMES = 4000; // Bound on a game that never ends.

	logic clock;
	logic reset_n;
	logic up;
	world_t world;
	score_t score;
	logic frame;
	logic gameOver;

	logic [31:0] randState; // Stimulus LFSR.
	int cyclesSince; // Cycles since the last frame or reset release.
	int runLeft; // Ticks before up is drawn again.

	`include "waveGameModel.svh"

	waveGame #(
		.TICK_CYCLES(TICK_CYCLES)
	) DUT (
		.clock(clock),
		.reset_n(reset_n),
		.up(up),
		.world(world),
		.score(score),
		.frame(frame),
		.gameOver(gameOver)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// Taps 32, 22, 2, 1.
	function automatic logic randomBit();
		randState = {randState[30:0], randState[31] ^ randState[21] ^ randState[1] ^ randState[0]};
		return randState[0];
	endfunction

	// Hold one direction for a run of 1 to 16 ticks.
	task automatic chooseUp();
		if (runLeft == 0) begin
			up = randomBit();
			runLeft = 1;
			for (int i = 0; i < 4; i++) begin
				runLeft = runLeft + (int'(randomBit()) << i);
			end
		end
		runLeft--;
	endtask

	task automatic advance();
		@(posedge clock);
		#1; // Outputs are settled, inputs change here.
		cyclesSince++;
	endtask

	task automatic checkValue(input string testName, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("Mismatch in %s: expected %0h, actual %0h", testName, expected, actual);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	task automatic checkTrue(input logic condition, input string what);
		assert (condition) else begin
			$display("%s", what);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	task automatic waitForFrame(input int expectedGap);
		int waited;

		waited = 0;
		do begin
			advance();
			waited++;
			checkTrue(!gameOver, "The game ended on a tick that the ship survives");
			checkTrue(waited <= TIMEOUT_CYCLES, "Timed out waiting for a frame pulse");
		end while (!frame);
		checkValue("tick spacing", expectedGap, cyclesSince);
		cyclesSince = 0;
	endtask

	task automatic waitForGameOver(input int expectedGap);
		int waited;

		waited = 0;
		do begin
			advance();
			waited++;
			checkTrue(!frame, "A frame pulsed on a tick where the ship hits a wall");
			checkTrue(waited <= TIMEOUT_CYCLES, "Timed out waiting for game over");
		end while (!gameOver);
		checkValue("game over timing", expectedGap, cyclesSince);
	endtask

	initial begin
		logic survived;
		int gap;

		reset_n = 1'b0;
		up = 1'b0;
		randState = 32'h7393;
		runLeft = 0;
		cyclesSince = 0;
		gap = 0;
		resetModel();
		repeat (3) begin
			advance();
		end
		checkValue("reset world", modelWorld, world);
		checkValue("reset score", 0, score);
		checkValue("reset frame", 0, frame);
		checkValue("reset gameOver", 0, gameOver);

		chooseUp(); // Direction for the first tick.
		reset_n = 1'b1;
		cyclesSince = 0;
		survived = 1'b1;
		while (survived) begin
			gap = (modelFrames == 0) ? TICK_CYCLES + 3 : TICK_CYCLES;
			stepModel(up, survived);
			if (survived) begin
				waitForFrame(gap);
				checkValue("ship motion", modelWorld.ship, world.ship);
				checkValue("upper wall motion", modelWorld.upper, world.upper);
				checkValue("lower wall motion", modelWorld.lower, world.lower);
				advance();
				checkValue("score", expectedScore(modelFrames), score);
				checkTrue(modelFrames < MAX_FRAMES, "The game did not end within the frame limit");
				chooseUp();
			end
		end

		// Collision tick. gameOver follows the check cycle.
		waitForGameOver(gap + 1);
		checkValue("game over world", modelWorld, world);
		checkValue("game over score", expectedScore(modelFrames), score);
		repeat (3 * TICK_CYCLES) begin
			advance();
			checkValue("frozen gameOver", 1, gameOver);
			checkValue("frozen frame", 0, frame);
			checkValue("frozen world", modelWorld, world);
			checkValue("frozen score", expectedScore(modelFrames), score);
		end
		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

/* waveGame.f */
+incdir+bench
hw/wavePkg.sv
hw/gameTicker.sv
hw/shipDatapath.sv
hw/hallwayTracers.sv
hw/scoreCounter.sv
hw/gameController.sv
hw/waveGame.sv
bench/waveGameTb.sv

/* Bender.yml */
package:
  name: waveGame

sources:
  - hw/wavePkg.sv
  - hw/gameTicker.sv
  - hw/shipDatapath.sv
  - hw/hallwayTracers.sv
  - hw/scoreCounter.sv
  - hw/gameController.sv
  - hw/waveGame.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/waveGameTb.sv
